// File: verilog.f
src/mem_map_pkg.sv
src/cpu_bus_decoder.sv
src/ctrl_reg_file.sv
src/duty_phase_ram.sv
src/mod_sample_ram.sv
src/host_mem_map.sv
tb/cpu_bus_bfm.sv
tb/tb_host_mem_map.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the host memory map testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f verilog.f --top-module tb_host_mem_map -Mdir "$OBJ_DIR" -o sim_tb
if [ $? -ne 0 ]; then
  echo "run_sim: verilator build failed"
  exit 1
fi

"./$OBJ_DIR/sim_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "run_sim: simulator exited with status $sim_status"
  exit 1
fi

if grep -q -x "Simulation completed successfully" "$LOG_FILE"; then
  echo "run_sim: PASS"
  exit 0
else
  echo "run_sim: FAIL"
  exit 1
fi

// File: tb/tb_host_mem_map.sv
// tb_host_mem_map: clock, reset, stimulus table, checks, timeout and verdict.
`timescale 1ns/1ps
`default_nettype none

module tb_host_mem_map;

  typedef enum logic [2:0] {
    op_write, op_bus_read, op_fab_duty_phase, op_fab_mod, op_port
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [1:0]  win;
    logic [15:0] addr;
    logic [15:0] data;
    logic [63:0] expected;
  } entry_t;

  logic        CPU_CKIO = 1'b0;
  logic        rst;
  logic [7:0]  tr_idx;
  logic [15:0] mod_idx;
  wire  [15:0] cpu_addr;
  wire  [15:0] cpu_data_in;
  wire         cpu_cs1_n;
  wire         cpu_we0_n;
  wire  [15:0] cpu_data_out;
  wire         force_fan;
  wire         sync;
  wire  [15:0] mod_cycle;
  wire  [31:0] mod_freq_div;
  wire  [15:0] stm_cycle;
  wire  [63:0] ecat_sync_time;
  wire  [mem_map_pkg::DUTY_PHASE_WIDTH-1:0] duty;
  wire  [mem_map_pkg::DUTY_PHASE_WIDTH-1:0] phase;
  wire  [7:0]  mod_sample;

  entry_t stim_q[$];
  integer seed = 32'h225645f8;
  int     errors = 0;
  int     checks = 0;
  int     cycles = 0;
  int     wr_pulses = 0;
  int     num_writes = 0;
  int     timeout_cycles = 200;

  always #5 CPU_CKIO = ~CPU_CKIO;

  host_mem_map dut_i (
    .CPU_CKIO(CPU_CKIO), .rst(rst), .cpu_addr(cpu_addr), .cpu_data_in(cpu_data_in),
    .cpu_cs1_n(cpu_cs1_n), .cpu_we0_n(cpu_we0_n), .cpu_data_out(cpu_data_out),
    .force_fan(force_fan), .sync(sync), .mod_cycle(mod_cycle),
    .mod_freq_div(mod_freq_div), .stm_cycle(stm_cycle), .ecat_sync_time(ecat_sync_time),
    .tr_idx(tr_idx), .duty(duty), .phase(phase), .mod_idx(mod_idx), .mod_sample(mod_sample)
  );

  cpu_bus_bfm bfm_i (
    .CPU_CKIO(CPU_CKIO), .cpu_data_out(cpu_data_out), .cpu_addr(cpu_addr),
    .cpu_data_in(cpu_data_in), .cpu_cs1_n(cpu_cs1_n), .cpu_we0_n(cpu_we0_n)
  );

  // every write access must give exactly one strobe.
  always @(posedge CPU_CKIO) begin
    if (!rst && dut_i.wr_stb) begin
      wr_pulses++;
    end
  end

  always @(posedge CPU_CKIO) begin
    cycles++;
    if (cycles > timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error: time %0t, %s = %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic add_entry(input op_e op, input logic [1:0] win, input logic [15:0] addr,
                           input logic [15:0] data, input logic [63:0] expected);
    stim_q.push_back(entry_t'{op, win, addr, data, expected});
    if (op == op_write) begin
      num_writes++;
    end
  endtask

  task automatic write_entry(input logic [1:0] win, input logic [13:0] addr,
                             input logic [15:0] data);
    add_entry(op_write, win, {2'b00, addr}, data, 64'h0);
  endtask

  task automatic read_entry(input logic [1:0] win, input logic [13:0] addr,
                            input logic [63:0] expected);
    add_entry(op_bus_read, win, {2'b00, addr}, 16'h0000, expected);
  endtask

  task automatic port_entry(input int id, input logic [63:0] expected);
    add_entry(op_port, 2'b00, 16'(id), 16'h0000, expected);
  endtask

  function automatic logic [63:0] port_value(input logic [15:0] id);
    case (id)
      16'd0:   return 64'(force_fan);
      16'd1:   return 64'(sync);
      16'd2:   return 64'(mod_cycle);
      16'd3:   return 64'(mod_freq_div);
      16'd4:   return 64'(stm_cycle);
      16'd5:   return ecat_sync_time;
      default: return 64'(cpu_data_out);
    endcase
  endfunction

  function automatic string port_name(input logic [15:0] id);
    case (id)
      16'd0:   return "force_fan";
      16'd1:   return "sync";
      16'd2:   return "mod_cycle";
      16'd3:   return "mod_freq_div";
      16'd4:   return "stm_cycle";
      16'd5:   return "ecat_sync_time";
      default: return "cpu_data_out";
    endcase
  endfunction

  task automatic build_stimulus();
    logic [15:0] v [9];
    logic [13:0] ctrl_addr [9];
    logic [15:0] ctl_both;
    logic [15:0] ph;
    logic [15:0] du;
    logic [15:0] d0;
    logic [15:0] d1;
    logic [13:0] a;
    logic [31:0] r;
    int          idx [5];
    ctrl_addr = '{mem_map_pkg::ADDR_CTL_REG, mem_map_pkg::ADDR_MOD_CYCLE,
                  mem_map_pkg::ADDR_MOD_FREQ_DIV_0, mem_map_pkg::ADDR_MOD_FREQ_DIV_1,
                  mem_map_pkg::ADDR_STM_CYCLE, mem_map_pkg::ADDR_EC_SYNC_TIME_0,
                  mem_map_pkg::ADDR_EC_SYNC_TIME_1, mem_map_pkg::ADDR_EC_SYNC_TIME_2,
                  mem_map_pkg::ADDR_EC_SYNC_TIME_3};
    // reset values, port 6 is cpu_data_out.
    for (int p = 0; p < 7; p++) begin
      port_entry(p, 64'h0);
    end
    for (int k = 0; k < 9; k++) begin
      v[k] = 16'($random(seed));
      write_entry(mem_map_pkg::sel_controller, ctrl_addr[k], v[k]);
    end
    port_entry(0, 64'(v[0][mem_map_pkg::CTL_REG_FORCE_FAN_BIT]));
    port_entry(1, 64'(v[0][mem_map_pkg::CTL_REG_SYNC_BIT]));
    port_entry(2, 64'(v[1]));
    port_entry(3, 64'({v[3], v[2]}));
    port_entry(4, 64'(v[4]));
    port_entry(5, {v[8], v[7], v[6], v[5]});
    for (int k = 0; k < 9; k++) begin
      read_entry(mem_map_pkg::sel_controller, ctrl_addr[k], 64'(v[k]));
    end
    ctl_both = 16'h0000;
    ctl_both[mem_map_pkg::CTL_REG_FORCE_FAN_BIT] = 1'b1;
    ctl_both[mem_map_pkg::CTL_REG_SYNC_BIT] = 1'b1;
    write_entry(mem_map_pkg::sel_controller, mem_map_pkg::ADDR_CTL_REG, ctl_both);
    port_entry(0, 64'h1);
    port_entry(1, 64'h1);
    write_entry(mem_map_pkg::sel_controller, mem_map_pkg::ADDR_CTL_REG, 16'h0000);
    port_entry(0, 64'h0);
    port_entry(1, 64'h0);
    // unmapped words and the stm window read zero.
    read_entry(mem_map_pkg::sel_controller, 14'h005, 64'h0);
    read_entry(mem_map_pkg::sel_controller, 14'h3ff, 64'h0);
    write_entry(mem_map_pkg::sel_stm, 14'h010, 16'($random(seed)));
    read_entry(mem_map_pkg::sel_stm, 14'h010, 64'h0);
    r = $random(seed);
    idx = '{0, 1, 124, mem_map_pkg::NUM_TRANS - 1, int'(r % 32'(mem_map_pkg::NUM_TRANS))};
    for (int n = 0; n < 5; n++) begin
      ph = 16'($random(seed));
      du = 16'($random(seed));
      write_entry(mem_map_pkg::sel_normal, 14'(2 * idx[n]), ph);
      write_entry(mem_map_pkg::sel_normal, 14'(2 * idx[n] + 1), du);
      add_entry(op_fab_duty_phase, 2'b00, 16'(idx[n]), 16'h0000,
                64'({du[12:0], ph[12:0]}));
      read_entry(mem_map_pkg::sel_normal, 14'(2 * idx[n]), 64'(ph[12:0]));
      read_entry(mem_map_pkg::sel_normal, 14'(2 * idx[n] + 1), 64'(du[12:0]));
    end
    // same word address in both modulation banks.
    for (int n = 0; n < 3; n++) begin
      a  = (n == 0) ? 14'h0000 : ((n == 1) ? 14'h3fff : 14'($random(seed)));
      d0 = 16'($random(seed));
      d1 = ~d0 ^ 16'($random(seed) & 32'h0000_00f0);
      write_entry(mem_map_pkg::sel_controller, mem_map_pkg::ADDR_MOD_ADDR_OFFSET, 16'h0000);
      write_entry(mem_map_pkg::sel_mod, a, d0);
      write_entry(mem_map_pkg::sel_controller, mem_map_pkg::ADDR_MOD_ADDR_OFFSET, 16'h0001);
      write_entry(mem_map_pkg::sel_mod, a, d1);
      add_entry(op_fab_mod, 2'b00, {1'b0, a, 1'b0}, 16'h0000, 64'(d0[7:0]));
      add_entry(op_fab_mod, 2'b00, {1'b0, a, 1'b1}, 16'h0000, 64'(d0[15:8]));
      add_entry(op_fab_mod, 2'b00, {1'b1, a, 1'b0}, 16'h0000, 64'(d1[7:0]));
      add_entry(op_fab_mod, 2'b00, {1'b1, a, 1'b1}, 16'h0000, 64'(d1[15:8]));
      read_entry(mem_map_pkg::sel_controller, mem_map_pkg::ADDR_MOD_ADDR_OFFSET, 64'h1);
      read_entry(mem_map_pkg::sel_mod, a, 64'(d1));
      write_entry(mem_map_pkg::sel_controller, mem_map_pkg::ADDR_MOD_ADDR_OFFSET, 16'h0000);
      read_entry(mem_map_pkg::sel_mod, a, 64'(d0));
    end
  endtask

  task automatic apply_entry(input entry_t e);
    logic [15:0] rd;
    case (e.op)
      op_write: bfm_i.bus_write(e.win, e.addr[13:0], e.data);
      op_bus_read: begin
        bfm_i.bus_read(e.win, e.addr[13:0], rd);
        check_value("cpu_data_out", 64'(rd), e.expected);
      end
      op_fab_duty_phase: begin
        @(posedge CPU_CKIO);
        #1;
        tr_idx = e.addr[7:0];
        @(posedge CPU_CKIO);
        #1;
        check_value("duty", 64'(duty), 64'(e.expected[25:13]));
        check_value("phase", 64'(phase), 64'(e.expected[12:0]));
      end
      op_fab_mod: begin
        @(posedge CPU_CKIO);
        #1;
        mod_idx = e.addr;
        @(posedge CPU_CKIO);
        #1;
        check_value("mod_sample", 64'(mod_sample), e.expected);
      end
      default: check_value(port_name(e.addr), port_value(e.addr), e.expected);
    endcase
  endtask

  initial begin
    rst = 1'b1;
    tr_idx = 8'h00;
    mod_idx = 16'h0000;
    bfm_i.release_pins();
    build_stimulus();
    timeout_cycles = stim_q.size() * 12 + 200;
    repeat (16) @(posedge CPU_CKIO);
    #1;
    rst = 1'b0;
    foreach (stim_q[i]) begin
      apply_entry(stim_q[i]);
    end
    check_value("wr_stb pulses", 64'(wr_pulses), 64'(num_writes));
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/cpu_bus_bfm.sv
// cpu_bus_bfm: CPU bus driver with pin release, write and read tasks.
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_bfm (
  input  wire         CPU_CKIO,
  input  wire  [15:0] cpu_data_out,
  output logic [15:0] cpu_addr,
  output logic [15:0] cpu_data_in,
  output logic        cpu_cs1_n,
  output logic        cpu_we0_n
);

  // we0_n low time of the reference CPU.
  localparam int WE_LOW_CYCLES = 3;
  localparam int IDLE_CYCLES   = 2;

  task automatic release_pins();
    cpu_addr    = 16'h0000;
    cpu_data_in = 16'h0000;
    cpu_cs1_n   = 1'b1;
    cpu_we0_n   = 1'b1;
  endtask

  // cs1_n with address and data first, we0_n one cycle later.
  task automatic bus_write(input logic [1:0] win, input logic [13:0] addr,
                           input logic [15:0] data);
    @(posedge CPU_CKIO);
    #1;
    cpu_addr    = {win, addr};
    cpu_data_in = data;
    cpu_cs1_n   = 1'b0;
    cpu_we0_n   = 1'b1;
    @(posedge CPU_CKIO);
    #1;
    cpu_we0_n = 1'b0;
    repeat (WE_LOW_CYCLES) @(posedge CPU_CKIO);
    #1;
    cpu_we0_n = 1'b1;
    @(posedge CPU_CKIO);
    #1;
    cpu_cs1_n = 1'b1;
    repeat (IDLE_CYCLES) @(posedge CPU_CKIO);
    #1;
  endtask

  task automatic bus_read(input logic [1:0] win, input logic [13:0] addr,
                          output logic [15:0] data);
    @(posedge CPU_CKIO);
    #1;
    cpu_addr  = {win, addr};
    cpu_cs1_n = 1'b0;
    cpu_we0_n = 1'b1;
    // first edge that sees cs1_n low.
    @(posedge CPU_CKIO);
    repeat (mem_map_pkg::READ_LATENCY) @(posedge CPU_CKIO);
    #1;
    data      = cpu_data_out;
    cpu_cs1_n = 1'b1;
    repeat (IDLE_CYCLES) @(posedge CPU_CKIO);
    #1;
  endtask

endmodule

`default_nettype wire

// File: src/host_mem_map.sv
// host_mem_map: cpu bus decoder, controller registers, duty/phase and modulation memories.
`timescale 1ns/1ps
`default_nettype none

module host_mem_map (
  input  wire                                      CPU_CKIO,
  input  wire                                      rst,
  input  wire [15:0]                               cpu_addr,
  input  wire [15:0]                               cpu_data_in,
  input  wire                                      cpu_cs1_n,
  input  wire                                      cpu_we0_n,
  output wire [15:0]                               cpu_data_out,
  output wire                                      force_fan,
  output wire                                      sync,
  output wire [15:0]                               mod_cycle,
  output wire [31:0]                               mod_freq_div,
  output wire [15:0]                               stm_cycle,
  output wire [63:0]                               ecat_sync_time,
  input  wire [7:0]                                tr_idx,
  output wire [mem_map_pkg::DUTY_PHASE_WIDTH-1:0]  duty,
  output wire [mem_map_pkg::DUTY_PHASE_WIDTH-1:0]  phase,
  input  wire [15:0]                               mod_idx,
  output wire [7:0]                                mod_sample
);

  mem_map_pkg::bram_select_e              sel;
  wire [mem_map_pkg::BUS_ADDR_WIDTH-1:0]  word_addr;
  wire [15:0]                             wr_data;
  wire                                    wr_stb;
  wire                                    rd_stb;
  wire [15:0]                             ctrl_rd_data;
  wire [15:0]                             normal_rd_data;
  wire [15:0]                             mod_rd_data;
  wire                                    mod_bank;

  cpu_bus_decoder decoder_i (
    .CPU_CKIO       (CPU_CKIO),
    .rst            (rst),
    .cpu_addr       (cpu_addr),
    .cpu_data_in    (cpu_data_in),
    .cpu_cs1_n      (cpu_cs1_n),
    .cpu_we0_n      (cpu_we0_n),
    .ctrl_rd_data   (ctrl_rd_data),
    .normal_rd_data (normal_rd_data),
    .mod_rd_data    (mod_rd_data),
    .cpu_data_out   (cpu_data_out),
    .sel            (sel),
    .word_addr      (word_addr),
    .wr_data        (wr_data),
    .wr_stb         (wr_stb),
    .rd_stb         (rd_stb)
  );

  ctrl_reg_file ctrl_i (
    .CPU_CKIO       (CPU_CKIO),
    .rst            (rst),
    .sel            (sel),
    .word_addr      (word_addr),
    .wr_data        (wr_data),
    .wr_stb         (wr_stb),
    .rd_stb         (rd_stb),
    .rd_data        (ctrl_rd_data),
    .force_fan      (force_fan),
    .sync           (sync),
    .mod_bank       (mod_bank),
    .mod_cycle      (mod_cycle),
    .mod_freq_div   (mod_freq_div),
    .stm_cycle      (stm_cycle),
    .ecat_sync_time (ecat_sync_time)
  );

  duty_phase_ram normal_i (
    .CPU_CKIO  (CPU_CKIO),
    .sel       (sel),
    .word_addr (word_addr),
    .wr_data   (wr_data),
    .wr_stb    (wr_stb),
    .rd_stb    (rd_stb),
    .tr_idx    (tr_idx),
    .rd_data   (normal_rd_data),
    .duty      (duty),
    .phase     (phase)
  );

  mod_sample_ram mod_i (
    .CPU_CKIO   (CPU_CKIO),
    .sel        (sel),
    .word_addr  (word_addr),
    .wr_data    (wr_data),
    .wr_stb     (wr_stb),
    .rd_stb     (rd_stb),
    .mod_bank   (mod_bank),
    .mod_idx    (mod_idx),
    .rd_data    (mod_rd_data),
    .mod_sample (mod_sample)
  );

endmodule

`default_nettype wire

// File: src/mod_sample_ram.sv
// mod_sample_ram: two bank modulation sample memory, word writes and byte reads.
`timescale 1ns/1ps
`default_nettype none

module mod_sample_ram (
  input  wire                                    CPU_CKIO,
  input  mem_map_pkg::bram_select_e              sel,
  input  wire [mem_map_pkg::BUS_ADDR_WIDTH-1:0]  word_addr,
  input  wire [15:0]                             wr_data,
  input  wire                                    wr_stb,
  input  wire                                    rd_stb,
  input  wire                                    mod_bank,
  input  wire [15:0]                             mod_idx,
  output logic [15:0]                            rd_data,
  output logic [7:0]                             mod_sample
);

  // bank in the top address bit, two samples per word.
  logic [15:0] mem [2 * mem_map_pkg::MOD_BANK_WORDS];

  logic [mem_map_pkg::BUS_ADDR_WIDTH:0] cpu_addr;
  logic [mem_map_pkg::BUS_ADDR_WIDTH:0] fab_addr;
  logic                                 wr_en;
  logic                                 rd_en;

  assign cpu_addr = {mod_bank, word_addr};
  assign fab_addr = mod_idx[15:1];
  assign wr_en    = wr_stb && (sel == mem_map_pkg::sel_mod);
  assign rd_en    = rd_stb && (sel == mem_map_pkg::sel_mod);

  always_ff @(posedge CPU_CKIO) begin
    if (wr_en) begin
      mem[cpu_addr] <= wr_data;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    if (rd_en) begin
      rd_data <= mem[cpu_addr];
    end
  end

  // low byte at even index.
  always_ff @(posedge CPU_CKIO) begin
    if (mod_idx[0]) begin
      mod_sample <= mem[fab_addr][15:8];
    end else begin
      mod_sample <= mem[fab_addr][7:0];
    end
  end

endmodule

`default_nettype wire

// File: src/duty_phase_ram.sv
// duty_phase_ram: per transducer phase and duty memory with fabric read port.
`timescale 1ns/1ps
`default_nettype none

module duty_phase_ram (
  input  wire                                         CPU_CKIO,
  input  mem_map_pkg::bram_select_e                   sel,
  input  wire [mem_map_pkg::BUS_ADDR_WIDTH-1:0]       word_addr,
  input  wire [15:0]                                  wr_data,
  input  wire                                         wr_stb,
  input  wire                                         rd_stb,
  input  wire [7:0]                                   tr_idx,
  output logic [15:0]                                 rd_data,
  output logic [mem_map_pkg::DUTY_PHASE_WIDTH-1:0]    duty,
  output logic [mem_map_pkg::DUTY_PHASE_WIDTH-1:0]    phase
);

  // even words hold phase, odd words hold duty.
  logic [mem_map_pkg::DUTY_PHASE_WIDTH-1:0] phase_mem [mem_map_pkg::NUM_TRANS];
  logic [mem_map_pkg::DUTY_PHASE_WIDTH-1:0] duty_mem  [mem_map_pkg::NUM_TRANS];

  logic       wr_en;
  logic       rd_en;
  logic       in_range;
  logic [7:0] cpu_idx;

  assign in_range = word_addr < mem_map_pkg::BUS_ADDR_WIDTH'(2 * mem_map_pkg::NUM_TRANS);
  assign cpu_idx  = word_addr[8:1];
  assign wr_en    = wr_stb && (sel == mem_map_pkg::sel_normal) && in_range;
  assign rd_en    = rd_stb && (sel == mem_map_pkg::sel_normal) && in_range;

  always_ff @(posedge CPU_CKIO) begin
    if (wr_en && word_addr[0]) begin
      duty_mem[cpu_idx] <= wr_data[mem_map_pkg::DUTY_PHASE_WIDTH-1:0];
    end
    if (wr_en && !word_addr[0]) begin
      phase_mem[cpu_idx] <= wr_data[mem_map_pkg::DUTY_PHASE_WIDTH-1:0];
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    if (rd_en) begin
      rd_data <= {{(16 - mem_map_pkg::DUTY_PHASE_WIDTH){1'b0}},
                  word_addr[0] ? duty_mem[cpu_idx] : phase_mem[cpu_idx]};
    end
  end

  // fabric port, both words in parallel.
  always_ff @(posedge CPU_CKIO) begin
    duty  <= duty_mem[tr_idx];
    phase <= phase_mem[tr_idx];
  end

  a_wr_in_range: assert property (@(posedge CPU_CKIO)
    (wr_stb && sel == mem_map_pkg::sel_normal) |-> in_range);

endmodule

`default_nettype wire

// File: src/ctrl_reg_file.sv
// ctrl_reg_file: controller registers, multiword assembly and readback.
`timescale 1ns/1ps
`default_nettype none

module ctrl_reg_file (
  input  wire                                    CPU_CKIO,
  input  wire                                    rst,
  input  mem_map_pkg::bram_select_e              sel,
  input  wire [mem_map_pkg::BUS_ADDR_WIDTH-1:0]  word_addr,
  input  wire [15:0]                             wr_data,
  input  wire                                    wr_stb,
  input  wire                                    rd_stb,
  output logic [15:0]                            rd_data,
  output logic                                   force_fan,
  output logic                                   sync,
  output logic                                   mod_bank,
  output logic [15:0]                            mod_cycle,
  output logic [31:0]                            mod_freq_div,
  output logic [15:0]                            stm_cycle,
  output logic [63:0]                            ecat_sync_time
);

  logic [15:0] ctl_reg;
  logic [15:0] mod_addr_offset;
  logic        wr_en;
  logic        rd_en;
  logic [15:0] rd_word;

  assign wr_en = wr_stb && (sel == mem_map_pkg::sel_controller);
  assign rd_en = rd_stb && (sel == mem_map_pkg::sel_controller);

  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      ctl_reg         <= 16'h0000;
      mod_addr_offset <= 16'h0000;
      mod_cycle       <= 16'h0000;
      mod_freq_div    <= 32'h0000_0000;
      stm_cycle       <= 16'h0000;
      ecat_sync_time  <= 64'h0;
    end else if (wr_en) begin
      case (word_addr)
        mem_map_pkg::ADDR_CTL_REG:         ctl_reg               <= wr_data;
        mem_map_pkg::ADDR_MOD_ADDR_OFFSET: mod_addr_offset       <= wr_data;
        mem_map_pkg::ADDR_MOD_CYCLE:       mod_cycle             <= wr_data;
        mem_map_pkg::ADDR_MOD_FREQ_DIV_0:  mod_freq_div[15:0]    <= wr_data;
        mem_map_pkg::ADDR_MOD_FREQ_DIV_1:  mod_freq_div[31:16]   <= wr_data;
        mem_map_pkg::ADDR_STM_CYCLE:       stm_cycle             <= wr_data;
        mem_map_pkg::ADDR_EC_SYNC_TIME_0:  ecat_sync_time[15:0]  <= wr_data;
        mem_map_pkg::ADDR_EC_SYNC_TIME_1:  ecat_sync_time[31:16] <= wr_data;
        mem_map_pkg::ADDR_EC_SYNC_TIME_2:  ecat_sync_time[47:32] <= wr_data;
        mem_map_pkg::ADDR_EC_SYNC_TIME_3:  ecat_sync_time[63:48] <= wr_data;
        default: ;
      endcase
    end
  end

  // readback, unmapped words give zero.
  always_comb begin
    case (word_addr)
      mem_map_pkg::ADDR_CTL_REG:         rd_word = ctl_reg;
      mem_map_pkg::ADDR_MOD_ADDR_OFFSET: rd_word = mod_addr_offset;
      mem_map_pkg::ADDR_MOD_CYCLE:       rd_word = mod_cycle;
      mem_map_pkg::ADDR_MOD_FREQ_DIV_0:  rd_word = mod_freq_div[15:0];
      mem_map_pkg::ADDR_MOD_FREQ_DIV_1:  rd_word = mod_freq_div[31:16];
      mem_map_pkg::ADDR_STM_CYCLE:       rd_word = stm_cycle;
      mem_map_pkg::ADDR_EC_SYNC_TIME_0:  rd_word = ecat_sync_time[15:0];
      mem_map_pkg::ADDR_EC_SYNC_TIME_1:  rd_word = ecat_sync_time[31:16];
      mem_map_pkg::ADDR_EC_SYNC_TIME_2:  rd_word = ecat_sync_time[47:32];
      mem_map_pkg::ADDR_EC_SYNC_TIME_3:  rd_word = ecat_sync_time[63:48];
      default:                           rd_word = 16'h0000;
    endcase
  end

  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      rd_data <= 16'h0000;
    end else if (rd_en) begin
      rd_data <= rd_word;
    end
  end

  assign force_fan = ctl_reg[mem_map_pkg::CTL_REG_FORCE_FAN_BIT];
  assign sync      = ctl_reg[mem_map_pkg::CTL_REG_SYNC_BIT];

  // bank select for cpu writes into the modulation window.
  assign mod_bank = mod_addr_offset[0];

endmodule

`default_nettype wire

// File: src/cpu_bus_decoder.sv
// cpu_bus_decoder: bus pin capture, strobe FSM and read data multiplexer.
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_decoder (
  input  wire                              CPU_CKIO,
  input  wire                              rst,
  input  wire [15:0]                       cpu_addr,
  input  wire [15:0]                       cpu_data_in,
  input  wire                              cpu_cs1_n,
  input  wire                              cpu_we0_n,
  input  wire [15:0]                       ctrl_rd_data,
  input  wire [15:0]                       normal_rd_data,
  input  wire [15:0]                       mod_rd_data,
  output logic [15:0]                      cpu_data_out,
  output mem_map_pkg::bram_select_e        sel,
  output logic [mem_map_pkg::BUS_ADDR_WIDTH-1:0] word_addr,
  output logic [15:0]                      wr_data,
  output logic                             wr_stb,
  output logic                             rd_stb
);

  logic cs_q;
  logic we_q;
  mem_map_pkg::bus_state_e state;

  // pins sampled once per edge.
  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      cs_q <= 1'b0;
      we_q <= 1'b0;
      sel  <= mem_map_pkg::sel_controller;
    end else begin
      cs_q <= ~cpu_cs1_n;
      we_q <= ~cpu_we0_n;
      sel  <= mem_map_pkg::bram_select_e'(cpu_addr[15:14]);
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    word_addr <= cpu_addr[mem_map_pkg::BUS_ADDR_WIDTH-1:0];
    wr_data   <= cpu_data_in;
  end

  // one strobe per access, one write per we0_n low period.
  always_ff @(posedge CPU_CKIO) begin
    if (rst) begin
      state  <= mem_map_pkg::bus_idle;
      wr_stb <= 1'b0;
      rd_stb <= 1'b0;
    end else begin
      wr_stb <= 1'b0;
      rd_stb <= 1'b0;
      case (state)
        mem_map_pkg::bus_idle: begin
          if (cs_q && we_q) begin
            wr_stb <= 1'b1;
            state  <= mem_map_pkg::bus_done;
          end else if (cs_q) begin
            rd_stb <= 1'b1;
            state  <= mem_map_pkg::bus_active;
          end
        end
        mem_map_pkg::bus_active: begin
          if (!cs_q) begin
            state <= mem_map_pkg::bus_idle;
          end else if (we_q && !rd_stb) begin
            wr_stb <= 1'b1;
            state  <= mem_map_pkg::bus_done;
          end
        end
        mem_map_pkg::bus_done: begin
          if (!cs_q) begin
            state <= mem_map_pkg::bus_idle;
          end else if (!we_q) begin
            // we0_n released, rearm for another write.
            state <= mem_map_pkg::bus_active;
          end
        end
        default: state <= mem_map_pkg::bus_idle;
      endcase
    end
  end

  always_comb begin
    case (sel)
      mem_map_pkg::sel_controller: cpu_data_out = ctrl_rd_data;
      mem_map_pkg::sel_mod:        cpu_data_out = mod_rd_data;
      mem_map_pkg::sel_normal:     cpu_data_out = normal_rd_data;
      default:                     cpu_data_out = 16'h0000;
    endcase
  end

  a_stb_exclusive: assert property (@(posedge CPU_CKIO) disable iff (rst)
    !(wr_stb && rd_stb));

  a_stb_single_cycle: assert property (@(posedge CPU_CKIO) disable iff (rst)
    (wr_stb || rd_stb) |=> !(wr_stb || rd_stb));

endmodule

`default_nettype wire

// File: src/mem_map_pkg.sv
// package mem_map_pkg: window selects, register map, sizes and bus states.
`default_nettype none

package mem_map_pkg;

  // top two bits of the cpu word address.
  typedef enum logic [1:0] {
    sel_controller = 2'd0,
    sel_mod        = 2'd1,
    sel_normal     = 2'd2,
    sel_stm        = 2'd3
  } bram_select_e;

  typedef enum logic [1:0] {
    bus_idle   = 2'd0,
    bus_active = 2'd1,
    bus_done   = 2'd2
  } bus_state_e;

  localparam int NUM_TRANS        = 249;
  localparam int DUTY_PHASE_WIDTH = 13;
  localparam int BUS_ADDR_WIDTH   = 14;
  localparam int MOD_BANK_WORDS   = 16384;

  // cycles from cs1_n sampled low to valid read data.
  localparam int READ_LATENCY = 2;

  // controller window word addresses.
  localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_CTL_REG         = 14'h000;
  localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_EC_SYNC_TIME_0  = 14'h011;
  localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_EC_SYNC_TIME_1  = 14'h012;
  localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_EC_SYNC_TIME_2  = 14'h013;
  localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_EC_SYNC_TIME_3  = 14'h014;
  localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_MOD_ADDR_OFFSET = 14'h020;
  localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_MOD_CYCLE       = 14'h021;
  localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_MOD_FREQ_DIV_0  = 14'h022;
  localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_MOD_FREQ_DIV_1  = 14'h023;
  localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_STM_CYCLE       = 14'h041;

  // ctl_reg bit positions.
  localparam int CTL_REG_FORCE_FAN_BIT = 4;
  localparam int CTL_REG_SYNC_BIT      = 8;

endpackage

`default_nettype wire
